// ==== common/sift_pkg.sv ====
package sift_pkg;

    // image geometry
    localparam int img_dim = 16;
    localparam int pix_w   = 8;
    localparam int coord_w = 4;

    // frame at 0 and the blur copy above it
    localparam int addr_w    = 9;
    localparam int mem_words = 1 << addr_w;
    localparam int blur_base = 256;

    // weights of the 3x3 sum add up to 16
    localparam int acc_w = pix_w + 4;

    localparam int thr_w = 4;

    // keypoint queue
    localparam int kp_depth = 16;
    localparam int kp_ptr_w = $clog2(kp_depth);

    typedef logic [pix_w-1:0]   pixel_t;
    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [coord_w-1:0] coord_t;

    typedef enum logic [1:0] {
        ph_idle,
        ph_blur,
        ph_detect
    } phase_t;

endpackage

// ==== logic/pixel_ram.sv ====
module pixel_ram (
    input  logic            clk,
    input  logic            we,
    input  sift_pkg::addr_t addr,
    input  sift_pkg::pixel_t wdata,
    output sift_pkg::pixel_t rdata
);

    sift_pkg::pixel_t mem [0:sift_pkg::mem_words-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // old data on a write cycle
    end

endmodule

// ==== logic/mem_arbiter.sv ====
module mem_arbiter (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             host_req,
    input  logic             host_we,
    input  sift_pkg::addr_t  host_addr,
    input  sift_pkg::pixel_t host_wdata,
    output logic             host_gnt,

    input  logic             det_req,
    input  sift_pkg::addr_t  det_addr,
    output logic             det_gnt,

    input  logic             blur_req,
    input  logic             blur_we,
    input  sift_pkg::addr_t  blur_addr,
    input  sift_pkg::pixel_t blur_wdata,
    output logic             blur_gnt,

    output logic             mem_we,
    output sift_pkg::addr_t  mem_addr,
    output sift_pkg::pixel_t mem_wdata
);

    sift_pkg::addr_t hold_addr; // keeps the address bus quiet when idle

    assign host_gnt = host_req;
    assign det_gnt  = det_req && !host_req;
    assign blur_gnt = blur_req && !host_req && !det_req;

    always_comb begin
        mem_we    = 1'b0;
        mem_addr  = hold_addr;
        mem_wdata = blur_wdata;
        if (host_gnt) begin
            mem_we    = host_we;
            mem_addr  = host_addr;
            mem_wdata = host_wdata;
        end else if (det_gnt) begin
            mem_addr  = det_addr; // read only
        end else if (blur_gnt) begin
            mem_we    = blur_we;
            mem_addr  = blur_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_addr <= '0;
        end else if (host_gnt || det_gnt || blur_gnt) begin
            hold_addr <= mem_addr;
        end
    end

endmodule

// ==== blur/blur_engine.sv ====
module blur_engine (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    output logic             req,
    output logic             we,
    output sift_pkg::addr_t  addr,
    output sift_pkg::pixel_t wdata,
    input  logic             gnt,
    input  sift_pkg::pixel_t rdata,
    output logic             done
);

    localparam sift_pkg::coord_t last_idx = sift_pkg::coord_t'(sift_pkg::img_dim - 1);

    logic                        busy;
    sift_pkg::coord_t            row;
    sift_pkg::coord_t            col;
    logic [1:0]                  tap_r;
    logic [1:0]                  tap_c;
    logic                        taps_done;
    logic                        pend;       // read data arrives this cycle
    logic [1:0]                  pend_sh;
    logic [sift_pkg::acc_w-1:0]  acc;

    logic [sift_pkg::coord_w:0]  nb_row;
    logic [sift_pkg::coord_w:0]  nb_col;
    logic                        in_img;
    logic                        rd_cyc;
    logic                        wr_cyc;
    logic                        tap_step;
    logic [1:0]                  tap_sh;

    always_comb begin
        // one below zero wraps to 31, one past 15 gives 16, both set the top bit
        nb_row   = {1'b0, row} + {3'b000, tap_r} - 5'd1;
        nb_col   = {1'b0, col} + {3'b000, tap_c} - 5'd1;
        in_img   = !nb_row[sift_pkg::coord_w] && !nb_col[sift_pkg::coord_w];
        rd_cyc   = busy && !taps_done && in_img;
        wr_cyc   = busy && taps_done && !pend;
        tap_step = busy && !taps_done && (!in_img || gnt); // zero taps skip the read
        tap_sh   = {1'b0, tap_r == 2'd1} + {1'b0, tap_c == 2'd1}; // weight 1, 2 or 4
        req      = rd_cyc || wr_cyc;
        we       = wr_cyc;
        wdata    = acc[sift_pkg::acc_w-1:4];
        if (wr_cyc) begin
            addr = sift_pkg::addr_t'(sift_pkg::blur_base) + sift_pkg::addr_t'({row, col});
        end else begin
            addr = sift_pkg::addr_t'({nb_row[sift_pkg::coord_w-1:0],
                                      nb_col[sift_pkg::coord_w-1:0]});
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            pend      <= 1'b0;
            row       <= '0;
            col       <= '0;
            tap_r     <= '0;
            tap_c     <= '0;
            taps_done <= 1'b0;
        end else begin
            done <= 1'b0;
            pend <= rd_cyc && gnt;
            if (start && !busy) begin
                busy      <= 1'b1;
                row       <= '0;
                col       <= '0;
                tap_r     <= '0;
                tap_c     <= '0;
                taps_done <= 1'b0;
            end else if (busy) begin
                if (tap_step) begin
                    if (tap_c == 2'd2) begin
                        tap_c <= '0;
                        if (tap_r == 2'd2) begin
                            tap_r     <= '0;
                            taps_done <= 1'b1;
                        end else begin
                            tap_r <= tap_r + 2'd1;
                        end
                    end else begin
                        tap_c <= tap_c + 2'd1;
                    end
                end
                if (wr_cyc && gnt) begin
                    taps_done <= 1'b0;
                    col       <= col + 1'b1;
                    if (col == last_idx) begin
                        row <= row + 1'b1;
                        if (row == last_idx) begin
                            busy <= 1'b0;
                            done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_cyc && gnt) begin
            pend_sh <= tap_sh;
        end
        if ((start && !busy) || (wr_cyc && gnt)) begin
            acc <= '0;
        end else if (pend) begin
            acc <= acc + (sift_pkg::acc_w'(rdata) << pend_sh);
        end
    end

endmodule

// ==== detect/keypoint_detector.sv ====
module keypoint_detector (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic [sift_pkg::thr_w-1:0] thr,
    output logic                      req,
    output sift_pkg::addr_t           addr,
    input  logic                      gnt,
    input  sift_pkg::pixel_t          rdata,
    output logic                      push,
    output sift_pkg::coord_t          kp_row,
    output sift_pkg::coord_t          kp_col,
    input  logic                      full,
    output logic                      done
);

    localparam sift_pkg::coord_t last_idx = sift_pkg::coord_t'(sift_pkg::img_dim - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_rd_org,
        st_rd_blr,
        st_wait,
        st_check
    } det_state_t;

    det_state_t       state;
    sift_pkg::coord_t row;
    sift_pkg::coord_t col;
    logic             got_org; // original pixel on rdata
    sift_pkg::pixel_t org_pix;
    sift_pkg::pixel_t diff;
    logic             hit;
    logic             advance;

    always_comb begin
        req = (state == st_rd_org) || (state == st_rd_blr);
        if (state == st_rd_blr) begin
            addr = sift_pkg::addr_t'(sift_pkg::blur_base) + sift_pkg::addr_t'({row, col});
        end else begin
            addr = sift_pkg::addr_t'({row, col});
        end
        diff    = (org_pix > rdata) ? org_pix - rdata : rdata - org_pix;
        push    = (state == st_check) && hit && !full;
        advance = (state == st_check) && (!hit || !full); // stall on a full queue
    end

    assign kp_row = row;
    assign kp_col = col;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            row     <= '0;
            col     <= '0;
            done    <= 1'b0;
            got_org <= 1'b0;
        end else begin
            done    <= 1'b0;
            got_org <= (state == st_rd_org) && gnt;
            case (state)
                st_idle: begin
                    if (start) begin
                        row   <= '0;
                        col   <= '0;
                        state <= st_rd_org;
                    end
                end
                st_rd_org: begin
                    if (gnt) begin
                        state <= st_rd_blr;
                    end
                end
                st_rd_blr: begin
                    if (gnt) begin
                        state <= st_wait;
                    end
                end
                st_wait: state <= st_check;
                st_check: begin
                    if (advance) begin
                        if (row == last_idx && col == last_idx) begin
                            state <= st_idle;
                            done  <= 1'b1;
                        end else begin
                            col   <= col + 1'b1;
                            state <= st_rd_org;
                            if (col == last_idx) begin
                                row <= row + 1'b1;
                            end
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (got_org) begin
            org_pix <= rdata;
        end
        if (state == st_wait) begin
            hit <= diff > sift_pkg::pixel_t'(thr); // blurred pixel on rdata
        end
    end

endmodule

// ==== logic/keypoint_fifo.sv ====
module keypoint_fifo (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  sift_pkg::coord_t in_row,
    input  sift_pkg::coord_t in_col,
    output logic             full,
    output logic             kp_valid,
    input  logic             kp_ready,
    output sift_pkg::coord_t kp_row,
    output sift_pkg::coord_t kp_col
);

    sift_pkg::coord_t row_mem [0:sift_pkg::kp_depth-1];
    sift_pkg::coord_t col_mem [0:sift_pkg::kp_depth-1];

    logic [sift_pkg::kp_ptr_w-1:0] wptr;
    logic [sift_pkg::kp_ptr_w-1:0] rptr;
    logic [sift_pkg::kp_ptr_w:0]   count;
    logic                          wr_en;
    logic                          rd_en;

    assign full     = (count == (sift_pkg::kp_ptr_w + 1)'(sift_pkg::kp_depth));
    assign kp_valid = (count != '0);
    assign wr_en    = push && !full;
    assign rd_en    = kp_valid && kp_ready;
    assign kp_row   = row_mem[rptr]; // head entry
    assign kp_col   = col_mem[rptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wptr <= wptr + 1'b1; // wraps at depth
            end
            if (rd_en) begin
                rptr <= rptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            row_mem[wptr] <= in_row;
            col_mem[wptr] <= in_col;
        end
    end

endmodule

// ==== logic/sift_top.sv ====
module sift_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       filter_on,
    input  logic [sift_pkg::thr_w-1:0] filter_threshold,
    output logic                       busy,
    output logic                       done,
    input  logic                       load_valid,
    input  sift_pkg::addr_t            load_addr,
    input  sift_pkg::pixel_t           load_data,
    output logic                       load_ready,
    output logic                       kp_valid,
    input  logic                       kp_ready,
    output sift_pkg::coord_t           kp_row,
    output sift_pkg::coord_t           kp_col
);

    sift_pkg::phase_t           phase;
    logic [sift_pkg::thr_w-1:0] thr_q; // zero when filtering is off
    logic                       blur_start;
    logic                       detect_start;
    logic                       blur_done;
    logic                       detect_done;

    logic                       mem_we;
    sift_pkg::addr_t            mem_addr;
    sift_pkg::pixel_t           mem_wdata;
    sift_pkg::pixel_t           mem_rdata;

    logic                       det_req;
    sift_pkg::addr_t            det_addr;
    logic                       det_gnt;
    logic                       blur_req;
    logic                       blur_we;
    sift_pkg::addr_t            blur_addr;
    sift_pkg::pixel_t           blur_wdata;
    logic                       blur_gnt;

    logic                       kp_push;
    sift_pkg::coord_t           det_row;
    sift_pkg::coord_t           det_col;
    logic                       kp_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase        <= sift_pkg::ph_idle;
            thr_q        <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
        end else begin
            done         <= 1'b0;
            blur_start   <= 1'b0;
            detect_start <= 1'b0;
            case (phase)
                sift_pkg::ph_idle: begin
                    if (start) begin
                        phase      <= sift_pkg::ph_blur;
                        thr_q      <= filter_on ? filter_threshold : '0;
                        busy       <= 1'b1;
                        blur_start <= 1'b1;
                    end
                end
                sift_pkg::ph_blur: begin
                    if (blur_done) begin
                        phase        <= sift_pkg::ph_detect;
                        detect_start <= 1'b1;
                    end
                end
                sift_pkg::ph_detect: begin
                    if (detect_done) begin
                        phase <= sift_pkg::ph_idle;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                end
                default: phase <= sift_pkg::ph_idle;
            endcase
        end
    end

    pixel_ram u_ram (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    mem_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (load_valid),
        .host_we    (1'b1), // host only writes
        .host_addr  (load_addr),
        .host_wdata (load_data),
        .host_gnt   (load_ready),
        .det_req    (det_req),
        .det_addr   (det_addr),
        .det_gnt    (det_gnt),
        .blur_req   (blur_req),
        .blur_we    (blur_we),
        .blur_addr  (blur_addr),
        .blur_wdata (blur_wdata),
        .blur_gnt   (blur_gnt),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    blur_engine u_blur (
        .clk   (clk),
        .rst_n (rst_n),
        .start (blur_start),
        .req   (blur_req),
        .we    (blur_we),
        .addr  (blur_addr),
        .wdata (blur_wdata),
        .gnt   (blur_gnt),
        .rdata (mem_rdata),
        .done  (blur_done)
    );

    keypoint_detector u_det (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (detect_start),
        .thr    (thr_q),
        .req    (det_req),
        .addr   (det_addr),
        .gnt    (det_gnt),
        .rdata  (mem_rdata),
        .push   (kp_push),
        .kp_row (det_row),
        .kp_col (det_col),
        .full   (kp_full),
        .done   (detect_done)
    );

    keypoint_fifo u_kp_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (kp_push),
        .in_row   (det_row),
        .in_col   (det_col),
        .full     (kp_full),
        .kp_valid (kp_valid),
        .kp_ready (kp_ready),
        .kp_row   (kp_row),
        .kp_col   (kp_col)
    );

endmodule

// ==== sim/tb_sift_top.sv ====
module tb_sift_top;

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {
        pat_flat,
        pat_spike,
        pat_ramp,
        pat_rand
    } pattern_t;

    typedef struct packed {
        pattern_t   pattern;
        logic [7:0] value;
        logic       filter_on;
        logic [3:0] threshold;
        logic       stall;      // random kp_ready
    } case_t;

    localparam int num_cases = 9;
    localparam int run_limit = 40000; // cycles per run
    localparam int npix      = sift_pkg::img_dim * sift_pkg::img_dim;

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic                       filter_on;
    logic [sift_pkg::thr_w-1:0] filter_threshold;
    logic                       busy;
    logic                       done;
    logic                       load_valid;
    sift_pkg::addr_t            load_addr;
    sift_pkg::pixel_t           load_data;
    logic                       load_ready;
    logic                       kp_valid;
    logic                       kp_ready;
    sift_pkg::coord_t           kp_row;
    sift_pkg::coord_t           kp_col;

    sift_pkg::pixel_t img [0:npix-1];
    sift_pkg::pixel_t rand_img [0:npix-1];
    logic [7:0]       exp_kp [$];  // {row, col} in raster order
    case_t            cases [0:num_cases-1];
    integer           seed;
    int               err_count;
    logic [31:0]      rnd;

    sift_top u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .start            (start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .busy             (busy),
        .done             (done),
        .load_valid       (load_valid),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .load_ready       (load_ready),
        .kp_valid         (kp_valid),
        .kp_ready         (kp_ready),
        .kp_row           (kp_row),
        .kp_col           (kp_col)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_error(input string msg);
        err_count++;
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic build_image(input case_t tc);
        for (int i = 0; i < npix; i++) begin
            case (tc.pattern)
                pat_flat:  img[i] = tc.value;
                pat_spike: img[i] = (i == 5 * sift_pkg::img_dim + 9) ? tc.value : 8'h00;
                pat_ramp:  img[i] = 8'((i % sift_pkg::img_dim) * int'(tc.value));
                default:   img[i] = rand_img[i];
            endcase
        end
    endtask

    // 1 2 1 / 2 4 2 / 1 2 1 over the frame, zero outside, then |orig - blur| > thr
    task automatic compute_model(input logic [3:0] thr);
        int sum;
        int nr;
        int nc;
        int wt;
        int blur;
        int diff;
        exp_kp.delete();
        for (int r = 0; r < sift_pkg::img_dim; r++) begin
            for (int c = 0; c < sift_pkg::img_dim; c++) begin
                sum = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        nr = r + dr;
                        nc = c + dc;
                        wt = (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1);
                        if (nr >= 0 && nr < sift_pkg::img_dim &&
                            nc >= 0 && nc < sift_pkg::img_dim) begin
                            sum += wt * int'(img[nr * sift_pkg::img_dim + nc]);
                        end
                    end
                end
                blur = sum / 16;
                diff = int'(img[r * sift_pkg::img_dim + c]) - blur;
                if (diff < 0) begin
                    diff = -diff;
                end
                if (diff > int'(thr)) begin
                    exp_kp.push_back({4'(r), 4'(c)});
                end
            end
        end
    endtask

    task automatic load_image();
        for (int i = 0; i < npix; i++) begin
            @(negedge clk);
            load_valid = 1'b1;
            load_addr  = sift_pkg::addr_t'(i);
            load_data  = img[i];
            #1;
            assert (load_ready == 1'b1)
                else report_error($sformatf("Mismatch load_ready: got 0x%h expected 0x1",
                                            load_ready));
        end
        @(negedge clk);
        load_valid = 1'b0;
        #1;
        assert (load_ready == 1'b0)
            else report_error($sformatf("Mismatch load_ready: got 0x%h expected 0x0",
                                        load_ready));
    endtask

    task automatic run_case(input int idx, input case_t tc);
        logic [3:0] eff_thr;
        int         got;
        int         cycles;
        logic       done_seen;
        build_image(tc);
        eff_thr = tc.filter_on ? tc.threshold : 4'd0;
        compute_model(eff_thr);
        load_image();

        @(negedge clk);
        start            = 1'b1;
        filter_on        = tc.filter_on;
        filter_threshold = tc.threshold;
        @(negedge clk);
        start            = 1'b0;
        filter_on        = !tc.filter_on; // must not reach the running job
        filter_threshold = ~tc.threshold;
        assert (busy == 1'b1)
            else report_error($sformatf("Mismatch busy after start: got 0x%h expected 0x1",
                                        busy));

        got       = 0;
        cycles    = 0;
        done_seen = 1'b0;
        while (!done_seen || kp_valid) begin
            assert (cycles < run_limit)
                else report_error($sformatf("case %0d timed out waiting for done", idx));
            if (done) begin
                assert (!done_seen)
                    else report_error($sformatf("done pulsed twice in case %0d", idx));
                assert (busy == 1'b0)
                    else report_error($sformatf("Mismatch busy at done: got 0x%h expected 0x0",
                                                busy));
                done_seen = 1'b1;
            end else if (!done_seen) begin
                assert (busy == 1'b1)
                    else report_error($sformatf("Mismatch busy before done: got 0x%h expected 0x1",
                                                busy));
            end
            if (tc.stall) begin
                rnd      = $random(seed);
                kp_ready = (rnd[2:0] == 3'd0); // slow enough to fill the queue
            end else begin
                kp_ready = 1'b1;
            end
            if (kp_valid && kp_ready) begin // transfer at the coming rising edge
                assert (got < exp_kp.size())
                    else report_error($sformatf("case %0d produced more keypoints than %0d",
                                                idx, exp_kp.size()));
                assert (kp_row == exp_kp[got][7:4])
                    else report_error($sformatf("Mismatch kp_row: got 0x%h expected 0x%h",
                                                kp_row, exp_kp[got][7:4]));
                assert (kp_col == exp_kp[got][3:0])
                    else report_error($sformatf("Mismatch kp_col: got 0x%h expected 0x%h",
                                                kp_col, exp_kp[got][3:0]));
                got++;
            end
            cycles++;
            @(negedge clk);
        end
        kp_ready = 1'b0;
        assert (got == exp_kp.size())
            else report_error($sformatf("Mismatch keypoint count: got 0x%h expected 0x%h",
                                        got, exp_kp.size()));
        $display("case %0d: %0d keypoints in %0d cycles", idx, got, cycles);
    endtask

    initial begin
        seed             = 84;
        err_count        = 0;
        rst_n            = 1'b0;
        start            = 1'b0;
        filter_on        = 1'b0;
        filter_threshold = '0;
        load_valid       = 1'b0;
        load_addr        = '0;
        load_data        = '0;
        kp_ready         = 1'b0;

        // pattern, value, filter_on, threshold, stall
        cases[0] = '{pat_flat,  8'd100, 1'b0, 4'd9,  1'b0}; // border only
        cases[1] = '{pat_spike, 8'd100, 1'b1, 4'd0,  1'b0};
        cases[2] = '{pat_spike, 8'd100, 1'b1, 4'd7,  1'b0};
        cases[3] = '{pat_spike, 8'd100, 1'b1, 4'd15, 1'b0};
        cases[4] = '{pat_rand,  8'd0,   1'b0, 4'd15, 1'b0}; // threshold ignored
        cases[5] = '{pat_rand,  8'd0,   1'b0, 4'd15, 1'b1};
        cases[6] = '{pat_ramp,  8'd12,  1'b1, 4'd5,  1'b0};
        cases[7] = '{pat_rand,  8'd0,   1'b1, 4'd9,  1'b0};
        cases[8] = '{pat_rand,  8'd0,   1'b1, 4'd3,  1'b1};

        for (int i = 0; i < npix; i++) begin
            rnd         = $random(seed);
            rand_img[i] = rnd[7:0];
        end

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        assert (busy == 1'b0)
            else report_error($sformatf("Mismatch busy: got 0x%h expected 0x0", busy));
        assert (done == 1'b0)
            else report_error($sformatf("Mismatch done: got 0x%h expected 0x0", done));
        assert (kp_valid == 1'b0)
            else report_error($sformatf("Mismatch kp_valid: got 0x%h expected 0x0", kp_valid));
        assert (load_ready == 1'b0)
            else report_error($sformatf("Mismatch load_ready: got 0x%h expected 0x0",
                                        load_ready));

        for (int i = 0; i < num_cases; i++) begin
            run_case(i, cases[i]);
        end

        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
common/sift_pkg.sv
logic/pixel_ram.sv
logic/mem_arbiter.sv
blur/blur_engine.sv
detect/keypoint_detector.sv
logic/keypoint_fifo.sv
logic/sift_top.sv
sim/tb_sift_top.sv

// ==== Makefile ====
TOP = tb_sift_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
